/* include/tetris_defines.svh */
// Fixed geometry of the Tetris playfield and 640x480 VGA timing, included by every RTL file
`ifndef TETRIS_DEFINES_SVH
`define TETRIS_DEFINES_SVH

//////////////////////////////////////////////////
// Board geometry
//////////////////////////////////////////////////
`define TET_ROWS      22    // Rows held in the board store
`define TET_COLS      10    // Cells per row
`define TET_VIS_ROWS  20    // Rows 0..19 are drawn and scanned
`define TET_BLOCK     15    // Cell pitch in pixels

// Grid window on screen, end is exclusive
`define TET_X0        245
`define TET_Y0        90
`define TET_X1        395
`define TET_Y1        390

//////////////////////////////////////////////////
// VGA 640x480 at 25 MHz pixel clock
//////////////////////////////////////////////////
`define VGA_H_TOTAL       800
`define VGA_H_ACT         640
`define VGA_H_SYNC_START  656   // After front porch
`define VGA_H_SYNC_WIDTH  96
`define VGA_V_TOTAL       525
`define VGA_V_ACT         480
`define VGA_V_SYNC_START  490
`define VGA_V_SYNC_WIDTH  2

`endif

/* hdl/tetris_pkg.sv */
// Shared types of the Tetris display path, imported by the RTL and the testbench
`include "tetris_defines.svh"

package tetris_pkg;

    // 3-bit RGB, one bit per gun
    typedef enum logic [2:0] {
        BLACK = 3'b000,
        RED   = 3'b100,
        WHITE = 3'b111
    } color_e;

    // Line-clear FSM
    typedef enum logic [1:0] {
        CLR_IDLE  = 2'd0,   // Waiting for a lock
        CLR_SCAN  = 2'd1,   // Testing one row per clock
        CLR_SHIFT = 2'd2    // Moving rows down over a full one
    } clr_state_e;

    typedef logic [4:0] row_idx_t;

    // Row 0 is the top row, bit c is column c
    typedef logic [`TET_ROWS-1:0][`TET_COLS-1:0] board_t;

    // One row write into the board store
    typedef struct packed {
        logic                 en;
        logic                 merge;   // 1 ORs data in, 0 replaces the row
        row_idx_t             row;
        logic [`TET_COLS-1:0] data;
    } row_wr_t;

    // Pixel as it leaves the renderer
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       active;
        color_e     color;
    } pixel_t;

endpackage

/* hdl/vga_timing.sv */
// Free-running VGA raster counters, feeds pixel coordinates and sync to the display path
`include "tetris_defines.svh"

module vga_timing (
    input  logic       clk,
    input  logic       rst_n,
    output logic [9:0] x,         // Pixel column, 0..799
    output logic [9:0] y,         // Line, 0..524
    output logic       hsync,     // Low during sync
    output logic       vsync,     // Low during sync
    output logic       active     // Inside 640x480
);

    logic line_end;    // Last pixel of a line
    logic frame_end;   // Last line of a frame

    assign line_end  = (x == 10'(`VGA_H_TOTAL - 1));
    assign frame_end = (y == 10'(`VGA_V_TOTAL - 1));

    //////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x <= '0;
        end else if (line_end) begin
            x <= '0;               // Wrap at end of line
        end else begin
            x <= x + 10'd1;
        end
    end

    // Line counter steps once per wrap of x
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                y <= '0;
            end else begin
                y <= y + 10'd1;
            end
        end
    end

    // Sync and blanking decode, aligned with x/y
    assign hsync  = !((x >= 10'(`VGA_H_SYNC_START)) &&
                      (x <  10'(`VGA_H_SYNC_START + `VGA_H_SYNC_WIDTH)));
    assign vsync  = !((y >= 10'(`VGA_V_SYNC_START)) &&
                      (y <  10'(`VGA_V_SYNC_START + `VGA_V_SYNC_WIDTH)));
    assign active = (x < 10'(`VGA_H_ACT)) && (y < 10'(`VGA_V_ACT));

    // Horizontal count never leaves the line
    a_h_range: assert property (@(posedge clk) disable iff (!rst_n)
        x < 10'(`VGA_H_TOTAL))
        else $error("vga_timing: x out of range %0d", x);

endmodule

/* hdl/board_store.sv */
// Occupancy board of the playfield in flops, written one row per clock through the arbiter
`include "tetris_defines.svh"

module board_store (
    input  logic                clk,
    input  logic                rst_n,
    input  tetris_pkg::row_wr_t wr,      // Granted row write
    output tetris_pkg::board_t  board    // Whole board, read by renderer and clear engine
);

    //////////////////////////////////////////////////
    // Row write
    //////////////////////////////////////////////////
    // Merge for piece lock, replace for line-clear shifts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            board <= '0;                                   // Empty playfield
        end else if (wr.en) begin
            if (wr.merge) begin
                board[wr.row] <= board[wr.row] | wr.data;  // Piece lands
            end else begin
                board[wr.row] <= wr.data;                  // Row moved or blanked
            end
        end
    end

    // Writers only address rows that exist, hidden rows included
    a_row_range: assert property (@(posedge clk) disable iff (!rst_n)
        wr.en |-> (wr.row < 5'(`TET_ROWS)))
        else $error("board_store: write to row %0d", wr.row);

endmodule

/* hdl/board_arbiter.sv */
// Fixed-priority grant of the board row write port, line clear ahead of piece lock
`include "tetris_defines.svh"

module board_arbiter (
    input  tetris_pkg::row_wr_t  clr_wr,       // Shift writes from line clear
    input  logic                 lock_req,     // Held by game logic until lock_done
    input  tetris_pkg::row_idx_t lock_row,
    input  logic [`TET_COLS-1:0] lock_mask,    // Cells of the landed piece in lock_row
    input  logic                 clear_busy,
    output tetris_pkg::row_wr_t  wr,           // To board store
    output logic                 lock_done     // One cycle, lock write granted
);

    import tetris_pkg::*;

    row_wr_t lock_wr;   // Lock peer request
    logic    lock_ok;   // Lock may go this cycle

    //////////////////////////////////////////////////
    // Lock peer
    //////////////////////////////////////////////////
    // Held off for the whole clear so shifts see a stable board
    assign lock_ok = lock_req && !clear_busy;

    always_comb begin
        lock_wr.en    = lock_ok;
        lock_wr.merge = 1'b1;          // Always OR into the row
        lock_wr.row   = lock_row;
        lock_wr.data  = lock_mask;
    end

    // Clear first, lock takes what is left
    always_comb begin
        if (clr_wr.en) begin
            wr = clr_wr;
        end else begin
            wr = lock_wr;
        end
    end

    // Busy flag alone gates the lock, it must cover every clear write
    assign lock_done = lock_ok;

    // No clock here, checked on every settle of the grant
    always_comb begin
        a_one_writer: assert (!(lock_done && clr_wr.en))
            else $error("board_arbiter: lock granted over a clear write");
    end

endmodule

/* hdl/line_clear.sv */
// Line-clear engine, scans visible rows after each lock and shifts the stack down over full rows
`include "tetris_defines.svh"

module line_clear (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,          // lock_done from the arbiter
    input  tetris_pkg::board_t  board,
    output tetris_pkg::row_wr_t clr_wr,         // Replace writes during shift
    output logic                clear_busy,
    output logic [7:0]          lines_cleared   // Running total
);

    import tetris_pkg::*;

    clr_state_e state;
    row_idx_t   scan_row;    // Row under test, bottom up
    row_idx_t   shift_row;   // Row being overwritten
    row_idx_t   above_row;   // Source row of the copy
    logic       row_full;

    assign row_full  = &board[scan_row];
    assign above_row = shift_row - 5'd1;

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= CLR_IDLE;
            scan_row      <= '0;
            shift_row     <= '0;
            lines_cleared <= '0;
        end else begin
            case (state)
                CLR_IDLE: begin
                    if (start) begin
                        state    <= CLR_SCAN;
                        scan_row <= 5'(`TET_VIS_ROWS - 1);   // Bottom visible row
                    end
                end
                CLR_SCAN: begin
                    if (row_full) begin
                        state         <= CLR_SHIFT;
                        shift_row     <= scan_row;
                        lines_cleared <= lines_cleared + 8'd1;
                    end else if (scan_row == '0) begin
                        state <= CLR_IDLE;               // Top reached, done
                    end else begin
                        scan_row <= scan_row - 5'd1;
                    end
                end
                CLR_SHIFT: begin
                    if (shift_row == '0) begin
                        state <= CLR_SCAN;               // Rescan same index
                    end else begin
                        shift_row <= shift_row - 5'd1;   // Walk upward
                    end
                end
                default: state <= CLR_IDLE;
            endcase
        end
    end

    // Copy the row above down; row 0 gets blanked
    always_comb begin
        clr_wr.en    = (state == CLR_SHIFT);
        clr_wr.merge = 1'b0;
        clr_wr.row   = shift_row;
        clr_wr.data  = (shift_row == '0) ? '0 : board[above_row];
    end

    assign clear_busy = (state != CLR_IDLE);

    // Arbiter keeps locks out while busy, so no restart mid-clear
    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !clear_busy)
        else $error("line_clear: lock completed during a clear");

endmodule

/* hdl/grid_render.sv */
// Playfield renderer, turns a raster coordinate and the board into a registered pixel colour
`include "tetris_defines.svh"

module grid_render (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [9:0]         x,
    input  logic [9:0]         y,
    input  logic               active,     // Visible area
    input  tetris_pkg::board_t board,
    input  logic               gameover,   // Turns grid lines red
    output tetris_pkg::pixel_t pix         // One clock after x/y
);

    import tetris_pkg::*;

    logic       in_grid;
    logic [9:0] off_x, off_y;     // Offset from grid origin
    logic [9:0] cell_x, cell_y;   // Cell coordinates, full width
    logic [3:0] col;
    logic [4:0] row;
    logic       on_line;
    pixel_t     pix_nxt;

    //////////////////////////////////////////////////
    // Geometry
    //////////////////////////////////////////////////
    always_comb begin
        in_grid = active &&
                  (x >= 10'(`TET_X0)) && (x < 10'(`TET_X1)) &&
                  (y >= 10'(`TET_Y0)) && (y < 10'(`TET_Y1));

        off_x  = x - 10'(`TET_X0);
        off_y  = y - 10'(`TET_Y0);
        cell_x = off_x / 10'(`TET_BLOCK);
        cell_y = off_y / 10'(`TET_BLOCK);
        col    = cell_x[3:0];
        row    = cell_y[4:0];

        // Pitch lines plus the closing right and bottom edges
        on_line = ((off_x % 10'(`TET_BLOCK)) == '0) ||
                  ((off_y % 10'(`TET_BLOCK)) == '0) ||
                  (x == 10'(`TET_X1 - 1)) ||
                  (y == 10'(`TET_Y1 - 1));
    end

    // Colour pick
    always_comb begin
        pix_nxt.x      = x;
        pix_nxt.y      = y;
        pix_nxt.active = active;
        if (!in_grid) begin
            pix_nxt.color = BLACK;                         // Background
        end else if (on_line) begin
            pix_nxt.color = gameover ? RED : WHITE;
        end else begin
            pix_nxt.color = board[row][col] ? WHITE : BLACK;   // Cell body
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix.x      <= '0;
            pix.y      <= '0;
            pix.active <= 1'b0;
            pix.color  <= BLACK;
        end else begin
            pix <= pix_nxt;
        end
    end

endmodule

/* hdl/tetris_display_top.sv */
// Top of the Tetris display subsystem, board with its two writers plus VGA timing and renderer
`include "tetris_defines.svh"

module tetris_display_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 lock_req,
    input  tetris_pkg::row_idx_t lock_row,
    input  logic [`TET_COLS-1:0] lock_mask,
    input  logic                 gameover,
    output tetris_pkg::pixel_t   pix,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 lock_done,
    output logic                 clear_busy,
    output logic [7:0]           lines_cleared
);

    import tetris_pkg::*;

    logic [9:0] x, y;     // Raster position
    logic       active;
    board_t     board;
    row_wr_t    clr_wr;   // Clear engine request
    row_wr_t    wr;       // Granted write

    //////////////////////////////////////////////////
    // Raster and render
    //////////////////////////////////////////////////
    vga_timing u_timing (
        .clk(clk), .rst_n(rst_n), .x(x), .y(y),
        .hsync(hsync), .vsync(vsync), .active(active)
    );

    grid_render u_render (
        .clk(clk), .rst_n(rst_n), .x(x), .y(y), .active(active),
        .board(board), .gameover(gameover), .pix(pix)
    );

    // Board and its writers
    board_store u_store (.clk(clk), .rst_n(rst_n), .wr(wr), .board(board));

    board_arbiter u_arb (
        .clr_wr(clr_wr), .lock_req(lock_req), .lock_row(lock_row),
        .lock_mask(lock_mask), .clear_busy(clear_busy),
        .wr(wr), .lock_done(lock_done)
    );

    line_clear u_clear (
        .clk(clk), .rst_n(rst_n), .start(lock_done), .board(board),
        .clr_wr(clr_wr), .clear_busy(clear_busy), .lines_cleared(lines_cleared)
    );

endmodule

/* verif/tetris_display_tb.sv */
// Testbench for the Tetris display top, checks rendered pixels, line clears, locks and sync
`include "tetris_defines.svh"

module tetris_display_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import tetris_pkg::*;

    localparam int    CLK_PERIOD    = 100;
    localparam int    FRAME_CYCLES  = `VGA_H_TOTAL * `VGA_V_TOTAL;   // 420000
    localparam int    N_FRAMES      = 4;        // Whole frames rendered by the sequence
    localparam int    MARGIN_CYCLES = 20000;    // Reset, locks and clears
    localparam longint WATCHDOG_NS  = longint'(N_FRAMES * FRAME_CYCLES + MARGIN_CYCLES)
                                      * CLK_PERIOD;
    localparam int    N_LOCKS       = 16;
    localparam int    WAIT_MAX      = 200;      // Longest clear is about 45 cycles

    logic                 clk;
    logic                 rst_n;
    logic                 lock_req;
    row_idx_t             lock_row;
    logic [`TET_COLS-1:0] lock_mask;
    logic                 gameover;
    pixel_t               pix;
    logic                 hsync, vsync;
    logic                 lock_done, clear_busy;
    logic [7:0]           lines_cleared;

    // Board model and raster model
    board_t model_board = '0;
    int     exp_lines   = 0;
    int     rx = 0, ry = 0;          // DUT x/y during the current cycle
    int     req_count = 0, done_count = 0;
    logic   busy_q = 1'b0;

    // Inputs of the previous cycle, as seen by the renderer's register
    logic   snap_valid = 1'b0;
    int     snap_x, snap_y;
    board_t snap_board;
    logic   snap_go, snap_busy;

    // Sync shape tracking
    longint cyc = 0;
    longint h_last = -1, v_last = -1;
    logic   hs_q = 1'b1, vs_q = 1'b1;
    int     vfalls = 0;

    tetris_display_top dut0 (
        .clk(clk), .rst_n(rst_n), .lock_req(lock_req), .lock_row(lock_row),
        .lock_mask(lock_mask), .gameover(gameover), .pix(pix), .hsync(hsync),
        .vsync(vsync), .lock_done(lock_done), .clear_busy(clear_busy),
        .lines_cleared(lines_cleared)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_eq(input logic [255:0] got, input logic [255:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("error at %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
            stop_run();
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected colour of one pixel
    function automatic color_e ref_color(input int px, input int py, input board_t b,
                                         input logic go);
        int         ox;
        int         oy;
        logic [4:0] r;
        logic [3:0] c;
        ox = px - `TET_X0;
        oy = py - `TET_Y0;
        r  = 5'(oy / `TET_BLOCK);    // Only used inside the grid
        c  = 4'(ox / `TET_BLOCK);
        if (px >= `VGA_H_ACT || py >= `VGA_V_ACT) begin
            ref_color = BLACK;                                   // Blanking
        end else if (px < `TET_X0 || px >= `TET_X1 || py < `TET_Y0 || py >= `TET_Y1) begin
            ref_color = BLACK;                                   // Background
        end else if ((ox % `TET_BLOCK == 0) || (oy % `TET_BLOCK == 0) ||
                     (px == `TET_X1 - 1) || (py == `TET_Y1 - 1)) begin
            ref_color = go ? RED : WHITE;                        // Grid line
        end else begin
            ref_color = b[r][c] ? WHITE : BLACK;
        end
    endfunction

    // Drop full visible rows, compact the rest downward, zeros on top
    function automatic board_t clear_rows(input board_t b, output int removed);
        board_t nb;
        int     dst;
        nb      = b;                        // Hidden rows 20 and 21 stay put
        dst     = `TET_VIS_ROWS - 1;
        removed = 0;
        for (int src = `TET_VIS_ROWS - 1; src >= 0; src--) begin
            if (&b[5'(src)]) begin
                removed++;
            end else begin
                nb[5'(dst)] = b[5'(src)];
                dst--;
            end
        end
        for (int r = dst; r >= 0; r--) begin
            nb[5'(r)] = '0;
        end
        return nb;
    endfunction

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Hold a lock request until granted, drop it the cycle after
    task automatic lock_piece(input logic [4:0] row, input logic [9:0] mask,
                              output int waited);
        lock_row  = row;
        lock_mask = mask;
        lock_req  = 1'b1;
        req_count++;
        waited    = 0;
        @(negedge clk);
        while (!lock_done) begin
            waited++;
            if (waited > WAIT_MAX) begin
                $display("lock request for row %0d was never granted", row);
                stop_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        lock_req = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (clear_busy) begin
            n++;
            if (n > WAIT_MAX) begin
                $display("line clear stayed busy for more than %0d cycles", WAIT_MAX);
                stop_run();
            end
            @(posedge clk);
            #1;
        end
    endtask

    //////////////////////////////////////////////////
    // Compare process, mid-cycle
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        int removed;
        if (rst_n) begin
            if (snap_valid) begin
                check_eq(256'(pix.x), 256'(snap_x), "pix.x");
                check_eq(256'(pix.y), 256'(snap_y), "pix.y");
                check_eq(256'(pix.active),
                         256'(snap_x < `VGA_H_ACT && snap_y < `VGA_V_ACT), "pix.active");
                if (!snap_busy) begin       // Board mid-shift is not modelled
                    check_eq(256'(pix.color),
                             256'(ref_color(snap_x, snap_y, snap_board, snap_go)),
                             "pixel colour");
                end
            end
            // Clear just ended, shift the model and compare the whole board
            if (busy_q && !clear_busy) begin
                model_board = clear_rows(model_board, removed);
                exp_lines   = exp_lines + removed;
                check_eq(256'(dut0.u_store.board), 256'(model_board), "board after clear");
                check_eq(256'(lines_cleared), 256'(exp_lines), "lines_cleared");
            end
            snap_valid = 1'b1;
            snap_x     = rx;
            snap_y     = ry;
            snap_board = model_board;
            snap_go    = gameover;
            snap_busy  = clear_busy;
            // Lock write lands at the coming edge
            if (lock_done) begin
                check_eq(256'(clear_busy), 256'(1'b0), "lock_done during a clear");
                model_board[lock_row] = model_board[lock_row] | lock_mask;
                done_count++;
            end
            busy_q = clear_busy;

            // Sync period and low width
            if (hs_q && !hsync) begin
                if (h_last >= 0) begin
                    check_eq(256'(cyc - h_last), 256'(`VGA_H_TOTAL), "hsync period");
                end
                h_last = cyc;
            end
            if (!hs_q && hsync) begin
                check_eq(256'(cyc - h_last), 256'(`VGA_H_SYNC_WIDTH), "hsync width");
            end
            if (vs_q && !vsync) begin
                if (v_last >= 0) begin
                    check_eq(256'(cyc - v_last), 256'(FRAME_CYCLES), "vsync period");
                end
                v_last = cyc;
                vfalls++;
            end
            if (!vs_q && vsync) begin
                check_eq(256'(cyc - v_last), 256'(`VGA_V_SYNC_WIDTH * `VGA_H_TOTAL),
                         "vsync width");
            end
            hs_q = hsync;
            vs_q = vsync;

            // Raster steps once per clock
            if (rx == `VGA_H_TOTAL - 1) begin
                rx = 0;
                ry = (ry == `VGA_V_TOTAL - 1) ? 0 : ry + 1;
            end else begin
                rx = rx + 1;
            end
            cyc++;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    initial begin
        int          waited;
        logic [31:0] seed;
        clk       = 1'b0;
        rst_n     = 1'b0;
        lock_req  = 1'b0;
        lock_row  = '0;
        lock_mask = '0;
        gameover  = 1'b0;
        seed      = 32'hfe29_a251;
        repeat (16) @(posedge clk);
        #1;
        check_eq(256'(pix.color), 256'(BLACK), "pix.color in reset");
        check_eq(256'({hsync, vsync}), 256'(2'b11), "syncs in reset");
        check_eq(256'({lock_done, clear_busy}), 256'(2'b00), "lock_done/clear_busy in reset");
        check_eq(256'(lines_cleared), 256'(0), "lines_cleared in reset");
        check_eq(256'(dut0.u_store.board), 256'(0), "board in reset");
        rst_n = 1'b1;

        run_cycles(FRAME_CYCLES);              // Empty board, white grid

        // Single full row, then a partial row that drops when the row below clears
        lock_piece(5'd19, 10'h3ff, waited);
        wait_idle();
        lock_piece(5'd18, 10'h0f0, waited);
        wait_idle();
        lock_piece(5'd19, 10'h3ff, waited);
        wait_idle();
        run_cycles(FRAME_CYCLES);              // Dropped row on screen
        lock_piece(5'd19, 10'h30f, waited);
        wait_idle();
        check_eq(256'(lines_cleared), 256'(3), "lines after scripted clears");

        repeat (N_LOCKS) begin
            seed = lcg_next(seed);
            lock_piece(5'(8 + seed[31:16] % 12), seed[27:18], waited);
            wait_idle();
        end

        // Second lock raised while the first one's clear is running
        lock_piece(5'd19, ~model_board[19], waited);
        @(posedge clk);
        #1;
        check_eq(256'(clear_busy), 256'(1'b1), "clear_busy at second lock");
        lock_piece(5'd5, 10'h081, waited);
        check_eq(256'(waited > 0), 256'(1'b1), "lock held off during clear");
        wait_idle();
        run_cycles(FRAME_CYCLES);

        gameover = 1'b1;                       // Grid lines go red
        run_cycles(FRAME_CYCLES);

        check_eq(256'(done_count), 256'(req_count), "lock_done pulses per request");
        check_eq(256'(vfalls >= 2), 256'(1'b1), "vsync pulses seen");
        $display("Testbench passed");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the test sequence did not finish",
                 WATCHDOG_NS);
        stop_run();
    end

endmodule

/* compile.f */
+incdir+include
hdl/tetris_pkg.sv
hdl/vga_timing.sv
hdl/board_store.sv
hdl/board_arbiter.sv
hdl/line_clear.sv
hdl/grid_render.sv
hdl/tetris_display_top.sv
verif/tetris_display_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the Tetris display testbench with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv -f compile.f \
    --top-module tetris_display_tb -Mdir obj_dir -o tetris_display_sim

./obj_dir/tetris_display_sim 2>&1 | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation PASSED"
